// ==== hw/lc3b_pkg.sv ====
`default_nettype none

package lc3b_pkg;

	typedef logic [15:0] lc3b_word_t;	// instruction word or pc
	typedef logic [2:0]  lc3b_reg_t;	// register index r0..r7

	// lc3b opcode field, bits 15:12
	typedef enum logic [3:0]
	{
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode_e;

	// one word, two readings; bit 5 (mode) tells add/and which one is live
	typedef union packed
	{
		struct packed
		{
			lc3b_opcode_e opcode;
			lc3b_reg_t    dr;
			lc3b_reg_t    sr1;
			logic         mode;		// 0 here
			logic [1:0]   pad;
			lc3b_reg_t    sr2;
		} r;
		struct packed
		{
			lc3b_opcode_e opcode;
			lc3b_reg_t    dr;
			lc3b_reg_t    sr1;
			logic         mode;		// 1 here
			logic [4:0]   imm;
		} i;
	} lc3b_instr_u;

	// opcodes that move the pc and so open a branch shadow
	function automatic logic is_control_op(input lc3b_opcode_e op);
		return (op == op_br) || (op == op_jmp) || (op == op_jsr) || (op == op_trap);
	endfunction

	localparam int default_fetch_depth   = 4;	// fifo entries = sender credits
	localparam int default_branch_shadow = 5;	// 4 bubbles then the squash slot

endpackage

`default_nettype wire

// ==== hw/fetch_credit_if.sv ====
`default_nettype none

// fetch buffer -> decode, one credit covers the if/id slot
interface fetch_credit_if;

	logic                valid;	// entry presented this cycle
	lc3b_pkg::lc3b_word_t ir;
	lc3b_pkg::lc3b_word_t pc;
	logic                credit;	// if/id slot freed, pulse

	modport source
	(
		output valid, ir, pc,
		input  credit
	);

	modport sink
	(
		input  valid, ir, pc,
		output credit
	);

endinterface

`default_nettype wire

// ==== hw/fetch_buffer.sv ====
`default_nettype none

module fetch_buffer
#(
	parameter int FETCH_DEPTH = lc3b_pkg::default_fetch_depth
)
(
	input  wire logic                 clk,
	input  wire logic                 reset,
	input  wire logic                 in_valid,
	input  wire lc3b_pkg::lc3b_word_t in_ir,
	input  wire lc3b_pkg::lc3b_word_t in_pc,
	output logic                      in_credit,
	fetch_credit_if.source            out
);

	localparam int PTR_W = (FETCH_DEPTH > 1) ? $clog2(FETCH_DEPTH) : 1;
	localparam int CNT_W = $clog2(FETCH_DEPTH + 1);

	lc3b_pkg::lc3b_word_t ir_mem [FETCH_DEPTH];
	lc3b_pkg::lc3b_word_t pc_mem [FETCH_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;		// entries held
	logic             dec_credit;	// credit toward decode, at most one
	logic             credit_avail;
	logic             pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(FETCH_DEPTH - 1))
			return '0;	// wrap
		return p + 1'b1;
	endfunction

	// a credit coming back this cycle can be spent right away
	assign credit_avail = dec_credit || out.credit;
	assign pop          = (count != '0) && credit_avail;

	assign out.valid = pop;	// presenting == popping
	assign out.ir    = ir_mem[rd_ptr];
	assign out.pc    = pc_mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			dec_credit <= 1'b1;	// if/id starts empty
			in_credit  <= 1'b0;
		end
		else
		begin
			if (in_valid)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			count      <= count + CNT_W'(in_valid) - CNT_W'(pop);
			dec_credit <= credit_avail && !pop;	// spent if presented
			in_credit  <= pop;	// slot freed, tell the sender
		end
	end

	// storage
	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			ir_mem[wr_ptr] <= in_ir;
			pc_mem[wr_ptr] <= in_pc;
		end
	end

	// outside sender pushed beyond the credits it was given
	a_no_push_when_full: assert property (@(posedge clk) disable iff (reset)
		in_valid |-> (count != CNT_W'(FETCH_DEPTH)));

	// decode returned a credit the buffer still holds, so a later entry
	// would be presented with no slot behind it
	a_no_extra_credit: assert property (@(posedge clk) disable iff (reset)
		!(dec_credit && out.credit));

endmodule : fetch_buffer

`default_nettype wire

// ==== hw/operand_use_decode.sv ====
`default_nettype none

module operand_use_decode
(
	input  wire lc3b_pkg::lc3b_instr_u ir,
	output logic                       writes_dr,
	output logic                       reads_sr1,
	output logic                       reads_sr2,
	output logic                       reads_dr_as_src
);

	always_comb
	begin
		writes_dr       = 1'b0;
		reads_sr1       = 1'b0;
		reads_sr2       = 1'b0;
		reads_dr_as_src = 1'b0;

		case (ir.r.opcode)
			lc3b_pkg::op_add, lc3b_pkg::op_and:
			begin
				writes_dr = 1'b1;
				reads_sr1 = 1'b1;
				reads_sr2 = !ir.i.mode;	// imm5 in bits 4:0 when mode set
			end
			lc3b_pkg::op_not, lc3b_pkg::op_shf:
			begin
				writes_dr = 1'b1;
				reads_sr1 = 1'b1;
			end
			lc3b_pkg::op_ldb, lc3b_pkg::op_ldr, lc3b_pkg::op_ldi:
			begin
				writes_dr = 1'b1;
				reads_sr1 = 1'b1;	// base register
			end
			lc3b_pkg::op_lea:
				writes_dr = 1'b1;	// pc relative only
			lc3b_pkg::op_stb, lc3b_pkg::op_str, lc3b_pkg::op_sti:
			begin
				reads_sr1       = 1'b1;	// base
				reads_dr_as_src = 1'b1;	// store data sits in the dr field
			end
			lc3b_pkg::op_jmp:
				reads_sr1 = 1'b1;
			lc3b_pkg::op_jsr:
				reads_sr1 = !ir.r.dr[2];	// jsrr form, bit 11 clear
			// jsr and trap write r7, never the dr field
			lc3b_pkg::op_br, lc3b_pkg::op_rti, lc3b_pkg::op_trap:
			begin
				writes_dr = 1'b0;
			end
			default:
			begin
				writes_dr = 1'b0;
			end
		endcase
	end

endmodule : operand_use_decode

`default_nettype wire

// ==== hw/hazard_ctrl.sv ====
`default_nettype none

module hazard_ctrl
#(
	parameter int BRANCH_SHADOW = lc3b_pkg::default_branch_shadow
)
(
	input  wire logic                 clk,
	input  wire logic                 reset,
	input  wire logic                 if_id_valid,
	input  wire lc3b_pkg::lc3b_word_t if_id_ir,
	input  wire logic                 id_ex_valid,
	input  wire lc3b_pkg::lc3b_word_t id_ex_ir,
	input  wire logic                 branch_taken,
	output logic                      stall,
	output logic                      squash
);

	localparam int CNT_W = $clog2(BRANCH_SHADOW + 1);

	lc3b_pkg::lc3b_instr_u if_id_u;
	lc3b_pkg::lc3b_instr_u id_ex_u;
	lc3b_pkg::lc3b_reg_t   load_dr;
	logic             if_id_sr1;
	logic             if_id_sr2;
	logic             if_id_dr_src;
	logic             id_ex_writes_dr;
	logic             id_ex_load;
	logic             load_use;
	logic             is_ctrl;
	logic [CNT_W-1:0] shadow_q;
	logic [CNT_W-1:0] shadow_d;
	logic             taken_q;	// branch_taken from the cycle before

	assign if_id_u = if_id_ir;
	assign id_ex_u = id_ex_ir;

	// what the younger instruction reads
	operand_use_decode u_if_id_use
	(
		.ir              (if_id_u),
		.writes_dr       (),
		.reads_sr1       (if_id_sr1),
		.reads_sr2       (if_id_sr2),
		.reads_dr_as_src (if_id_dr_src)
	);

	// what the older instruction writes
	operand_use_decode u_id_ex_use
	(
		.ir              (id_ex_u),
		.writes_dr       (id_ex_writes_dr),
		.reads_sr1       (),
		.reads_sr2       (),
		.reads_dr_as_src ()
	);

	assign load_dr    = id_ex_u.r.dr;
	assign id_ex_load = id_ex_valid && id_ex_writes_dr &&
		((id_ex_u.r.opcode == lc3b_pkg::op_ldb) ||
		 (id_ex_u.r.opcode == lc3b_pkg::op_ldi) ||
		 (id_ex_u.r.opcode == lc3b_pkg::op_ldr));

	// load result not ready in time for the next instruction
	always_comb
	begin
		load_use = 1'b0;
		if (id_ex_load && if_id_valid)
		begin
			if (if_id_sr1 && (if_id_u.r.sr1 == load_dr))
				load_use = 1'b1;
			if (if_id_sr2 && (if_id_u.r.sr2 == load_dr))
				load_use = 1'b1;	// register view only
			if (if_id_dr_src && (if_id_u.r.dr == load_dr))
				load_use = 1'b1;	// store data
		end
	end

	// all-zero word is a nop br and opens no shadow
	assign is_ctrl = if_id_valid && (if_id_ir != '0) &&
		lc3b_pkg::is_control_op(if_id_u.r.opcode);

	always_comb
	begin
		stall    = load_use;
		squash   = 1'b0;
		shadow_d = shadow_q;

		if (shadow_q == '0)
		begin
			if (is_ctrl && !load_use)	// branch leaves if/id this cycle
				shadow_d = CNT_W'(BRANCH_SHADOW);
		end
		else if (shadow_q > CNT_W'(1))
		begin
			shadow_d = shadow_q - 1'b1;
			stall    = 1'b1;	// bubble in the shadow
		end
		else
		begin
			shadow_d = '0;	// last slot decides between issue and drop
			squash   = taken_q && if_id_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			shadow_q <= '0;
			taken_q  <= 1'b0;
		end
		else
		begin
			shadow_q <= shadow_d;
			taken_q  <= branch_taken;
		end
	end

	// id/ex holds a shadow bubble in the squash slot, so no load-use then
	a_squash_not_stall: assert property (@(posedge clk) disable iff (reset)
		!(squash && stall));

	// the branch that opened the shadow has just moved into id/ex
	a_shadow_opener: assert property (@(posedge clk) disable iff (reset)
		(shadow_q == CNT_W'(BRANCH_SHADOW)) |->
			(id_ex_valid && lc3b_pkg::is_control_op(id_ex_u.r.opcode)));

endmodule : hazard_ctrl

`default_nettype wire

// ==== hw/decode_stage.sv ====
`default_nettype none

module decode_stage
(
	input  wire logic           clk,
	input  wire logic           reset,
	fetch_credit_if.sink        in,
	input  wire logic           stall,
	input  wire logic           squash,
	output logic                if_id_valid,
	output lc3b_pkg::lc3b_word_t if_id_ir,
	output logic                id_ex_valid,
	output lc3b_pkg::lc3b_word_t id_ex_ir,
	output logic                ex_valid,
	output lc3b_pkg::lc3b_word_t ex_ir,
	output lc3b_pkg::lc3b_word_t ex_pc
);

	lc3b_pkg::lc3b_word_t if_id_pc;
	lc3b_pkg::lc3b_word_t id_ex_pc;
	logic advance;	// if/id moves into id/ex

	assign advance = if_id_valid && !stall && !squash;

	// slot frees by advancing or by being dropped
	assign in.credit = if_id_valid && (squash || !stall);

	// if/id valid, a presented entry always has a slot thanks to the credit
	always_ff @(posedge clk)
	begin
		if (reset)
			if_id_valid <= 1'b0;
		else if (in.valid)
			if_id_valid <= 1'b1;
		else if (squash || !stall)
			if_id_valid <= 1'b0;	// moved on or squashed, nothing behind
	end

	always_ff @(posedge clk)
	begin
		if (in.valid)
		begin
			if_id_ir <= in.ir;
			if_id_pc <= in.pc;
		end
	end

	// id/ex valid, stall or squash leaves a bubble
	always_ff @(posedge clk)
	begin
		if (reset)
			id_ex_valid <= 1'b0;
		else
			id_ex_valid <= advance;
	end

	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			id_ex_ir <= if_id_ir;
			id_ex_pc <= if_id_pc;
		end
	end

	// execute reads id/ex directly
	assign ex_valid = id_ex_valid;
	assign ex_ir    = id_ex_ir;
	assign ex_pc    = id_ex_pc;

	// credit withheld under stall, so fetch must not present into a held slot
	a_no_overwrite_on_stall: assert property (@(posedge clk) disable iff (reset)
		(if_id_valid && stall) |-> !in.valid);

endmodule : decode_stage

`default_nettype wire

// ==== hw/lc3b_issue_pipe.sv ====
`default_nettype none

module lc3b_issue_pipe
#(
	parameter int FETCH_DEPTH   = lc3b_pkg::default_fetch_depth,
	parameter int BRANCH_SHADOW = lc3b_pkg::default_branch_shadow
)
(
	input  wire logic                 clk,
	input  wire logic                 reset,
	input  wire logic                 in_valid,
	input  wire lc3b_pkg::lc3b_word_t in_ir,
	input  wire lc3b_pkg::lc3b_word_t in_pc,
	output logic                      in_credit,
	input  wire logic                 branch_taken,	// from execute, about the last branch
	output logic                      ex_valid,
	output lc3b_pkg::lc3b_word_t      ex_ir,
	output lc3b_pkg::lc3b_word_t      ex_pc
);

	logic                 if_id_valid;
	lc3b_pkg::lc3b_word_t if_id_ir;
	logic                 id_ex_valid;
	lc3b_pkg::lc3b_word_t id_ex_ir;
	logic                 stall;
	logic                 squash;

	fetch_credit_if u_fetch_if ();

	fetch_buffer #(.FETCH_DEPTH(FETCH_DEPTH)) u_fetch_buffer
	(
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_ir     (in_ir),
		.in_pc     (in_pc),
		.in_credit (in_credit),
		.out       (u_fetch_if)
	);

	decode_stage u_decode_stage
	(
		.clk         (clk),
		.reset       (reset),
		.in          (u_fetch_if),
		.stall       (stall),
		.squash      (squash),
		.if_id_valid (if_id_valid),
		.if_id_ir    (if_id_ir),
		.id_ex_valid (id_ex_valid),
		.id_ex_ir    (id_ex_ir),
		.ex_valid    (ex_valid),
		.ex_ir       (ex_ir),
		.ex_pc       (ex_pc)
	);

	hazard_ctrl #(.BRANCH_SHADOW(BRANCH_SHADOW)) u_hazard_ctrl
	(
		.clk          (clk),
		.reset        (reset),
		.if_id_valid  (if_id_valid),
		.if_id_ir     (if_id_ir),
		.id_ex_valid  (id_ex_valid),
		.id_ex_ir     (id_ex_ir),
		.branch_taken (branch_taken),
		.stall        (stall),
		.squash       (squash)
	);

endmodule : lc3b_issue_pipe

`default_nettype wire

// ==== test/tb_lc3b_issue_pipe.sv ====
`default_nettype none

module tb_lc3b_issue_pipe;

	localparam int FETCH_DEPTH   = lc3b_pkg::default_fetch_depth;
	localparam int BRANCH_SHADOW = lc3b_pkg::default_branch_shadow;
	localparam int MAX_PROG      = 128;
	localparam int N_TESTS       = 6;
	localparam int WAIT_LIMIT    = 200;	// cycles any single wait may take

	logic                 clk;
	logic                 reset;
	logic                 in_valid;
	lc3b_pkg::lc3b_word_t in_ir;
	lc3b_pkg::lc3b_word_t in_pc;
	logic                 in_credit;
	logic                 branch_taken;
	logic                 ex_valid;
	lc3b_pkg::lc3b_word_t ex_ir;
	lc3b_pkg::lc3b_word_t ex_pc;

	lc3b_pkg::lc3b_word_t prog [MAX_PROG];	// pc of an entry is its index
	logic  taken [MAX_PROG];	// outcome reported by execute, branches only
	int    test_of [MAX_PROG];
	int    n_prog = 0;
	int    exp_idx [$];	// expected issue order
	int    exp_bub [$];	// bubbles expected right before each issue
	int    test_errs [N_TESTS] = '{default: 0};
	int    reset_errs = 0;
	int    credit_errs = 0;
	int    seed = 32'h1f967138;
	int    cyc;
	int    first_push_cyc = 0;
	int    n_checked = 0;
	logic  go = 1'b0;
	logic  comp_done = 1'b0;
	logic  sender_hung = 1'b0;
	logic  comp_hung = 1'b0;
	string test_name [N_TESTS];

	lc3b_issue_pipe #(.FETCH_DEPTH(FETCH_DEPTH), .BRANCH_SHADOW(BRANCH_SHADOW)) u_dut
	(
		.clk          (clk),
		.reset        (reset),
		.in_valid     (in_valid),
		.in_ir        (in_ir),
		.in_pc        (in_pc),
		.in_credit    (in_credit),
		.branch_taken (branch_taken),
		.ex_valid     (ex_valid),
		.ex_ir        (ex_ir),
		.ex_pc        (ex_pc)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial
	begin
		cyc = 0;
		forever
		begin
			@(posedge clk);
			cyc++;
		end
	end

	function automatic lc3b_pkg::lc3b_word_t make_word(input lc3b_pkg::lc3b_opcode_e op,
		input logic [2:0] a, input logic [2:0] b, input logic [5:0] low);
		return {op, a, b, low};	// opcode, dr/nzp, sr1/base, low six bits
	endfunction

	// br, jmp, jsr and trap move the pc; the zero word is a nop
	function automatic logic is_branch(input lc3b_pkg::lc3b_word_t w);
		logic [3:0] op;
		op = w[15:12];
		return (w != 16'h0000) && ((op == lc3b_pkg::op_br) || (op == lc3b_pkg::op_jmp) ||
			(op == lc3b_pkg::op_jsr) || (op == lc3b_pkg::op_trap));
	endfunction

	function automatic logic is_load(input lc3b_pkg::lc3b_word_t w);
		return (w[15:12] == lc3b_pkg::op_ldb) || (w[15:12] == lc3b_pkg::op_ldr) ||
			(w[15:12] == lc3b_pkg::op_ldi);
	endfunction

	// does instruction w read register r as a source
	function automatic logic reads_reg(input lc3b_pkg::lc3b_word_t w, input logic [2:0] r);
		logic sr1_hit;
		logic sr2_hit;
		logic dr_hit;
		sr1_hit = (w[8:6] == r);
		sr2_hit = (w[2:0] == r);
		dr_hit  = (w[11:9] == r);
		case (w[15:12])
			lc3b_pkg::op_add, lc3b_pkg::op_and:
				return sr1_hit || (!w[5] && sr2_hit);	// sr2 only in register form
			lc3b_pkg::op_not, lc3b_pkg::op_shf, lc3b_pkg::op_jmp,
			lc3b_pkg::op_ldb, lc3b_pkg::op_ldr, lc3b_pkg::op_ldi:
				return sr1_hit;
			lc3b_pkg::op_stb, lc3b_pkg::op_str, lc3b_pkg::op_sti:
				return sr1_hit || dr_hit;	// base and store data
			lc3b_pkg::op_jsr:
				return !w[11] && sr1_hit;	// jsrr
			default:
				return 1'b0;
		endcase
	endfunction

	// walks the program slot by slot at IF/ID with a full fetch buffer
	function automatic void ref_issue();
		int         pend;
		int         br_idx;
		int         i;
		logic       shadow;
		logic       load_prev;
		logic [2:0] load_dr;
		pend      = 0;
		br_idx    = 0;
		shadow    = 1'b0;
		load_prev = 1'b0;
		load_dr   = 3'd0;
		i         = 0;
		while (i < n_prog)
		begin
			if (shadow)
			begin
				shadow = 1'b0;
				pend += BRANCH_SHADOW - 1;	// shadow bubbles
				if (taken[br_idx])
				begin
					pend += 1;	// dropped instruction leaves an empty slot too
					load_prev = 1'b0;
					i++;
					continue;
				end
				// survivor of the shadow opens no shadow of its own
			end
			else
			begin
				if (load_prev && reads_reg(prog[i], load_dr))
					pend += 1;
				if (is_branch(prog[i]))
				begin
					shadow = 1'b1;
					br_idx = i;
				end
			end
			exp_idx.push_back(i);
			exp_bub.push_back(pend);
			pend      = 0;
			load_prev = is_load(prog[i]);
			load_dr   = prog[i][11:9];
			i++;
		end
	endfunction

	function automatic void add_instr(input lc3b_pkg::lc3b_word_t w, input logic tk,
		input int t);
		prog[n_prog]    = w;
		taken[n_prog]   = tk;
		test_of[n_prog] = t;
		n_prog++;
	endfunction

	function automatic void log_failure(input string msg);
		$display("FAIL %0t: %s", $time, msg);
	endfunction

	// execute reports the outcome of the branch now issued until the next issue
	initial
	begin
		branch_taken = 1'b0;
		forever
		begin
			@(posedge clk);
			#1;
			if (ex_valid)
				branch_taken = is_branch(ex_ir) ? taken[ex_pc[6:0]] : 1'b0;
		end
	end

	initial
	begin : sender
		int credits;
		int sent;
		int outstanding;
		int idle;
		credits     = FETCH_DEPTH;	// sender's share after reset
		sent        = 0;
		outstanding = 0;
		idle        = 0;
		while (!go && idle < WAIT_LIMIT)
		begin
			@(posedge clk);
			idle++;
		end
		if (!go)
		begin
			$display("ERROR: sender was never released after reset");
			sender_hung = 1'b1;
		end
		else
		begin
			idle = 0;
			while (sent < n_prog && idle < WAIT_LIMIT)
			begin
				@(posedge clk);
				#1;
				if (in_credit)
				begin
					credits++;
					outstanding--;
				end
				assert (outstanding >= 0 && outstanding <= FETCH_DEPTH)
				else
				begin
					log_failure($sformatf("%0d pushes outstanding", outstanding));
					credit_errs++;
				end
				if (credits > 0)
				begin
					in_valid = 1'b1;
					in_ir    = prog[sent];
					in_pc    = 16'(sent);
					if (sent == 0)
						first_push_cyc = cyc + 1;	// cycle count after the capturing edge
					credits--;
					outstanding++;
					sent++;
					idle = 0;
				end
				else
				begin
					in_valid = 1'b0;
					idle++;
				end
			end
			@(posedge clk);
			#1;
			in_valid = 1'b0;
			if (sent < n_prog)
			begin
				$display("ERROR: no credit came back for %0d cycles after %0d pushes",
					idle, sent);
				sender_hung = 1'b1;
			end
		end
	end

	initial
	begin : comparator
		int k;
		int idx;
		int t;
		int bub;
		int quiet;
		int errs;
		k     = 0;
		bub   = 0;
		quiet = 0;
		while (!go && quiet < WAIT_LIMIT)
		begin
			@(negedge clk);
			quiet++;
		end
		quiet = 0;
		while (k < exp_idx.size() && quiet < WAIT_LIMIT)
		begin
			@(negedge clk);
			if (ex_valid)
			begin
				idx = exp_idx[k];
				t   = test_of[idx];
				if (k == 0)
					assert (cyc - first_push_cyc == 2)
					else
					begin
						log_failure("first issue not two cycles after the first push");
						test_errs[0]++;
					end
				assert (ex_pc == 16'(idx) && ex_ir == prog[idx])
				else
				begin
					log_failure($sformatf("issued pc %h ir %h, expected pc %h ir %h",
						ex_pc, ex_ir, 16'(idx), prog[idx]));
					test_errs[t]++;
				end
				if (k > 0)
					assert (bub == exp_bub[k])
					else
					begin
						log_failure($sformatf("pc %h after %0d bubbles, expected %0d",
							ex_pc, bub, exp_bub[k]));
						test_errs[t]++;
					end
				if (k + 1 == exp_idx.size() || test_of[exp_idx[k + 1]] != t)
				begin
					errs = test_errs[t] + ((t == 0) ? reset_errs : 0) +
						((t == N_TESTS - 1) ? credit_errs : 0);
					$display("test %0d (%s): %0d errors", t, test_name[t], errs);
				end
				k++;
				n_checked = k;
				bub   = 0;
				quiet = 0;
			end
			else
			begin
				bub++;	// empty slot at execute
				quiet++;
			end
		end
		if (k < exp_idx.size())
		begin
			$display("ERROR: nothing issued for %0d cycles, %0d of %0d issues seen",
				quiet, k, exp_idx.size());
			comp_hung = 1'b1;
		end
		comp_done = 1'b1;
	end

	initial
	begin : main
		int i;
		int n;
		int total;
		int rnd;
		reset     = 1'b1;
		in_valid  = 1'b0;
		in_ir     = 16'h0000;
		in_pc     = 16'h0000;
		test_name = '{"reset", "load-use", "store sources", "branch not taken",
			"branch taken", "random mix"};

		add_instr(make_word(lc3b_pkg::op_add, 3'd0, 3'd0, 6'b100001), 1'b0, 0);
		add_instr(make_word(lc3b_pkg::op_add, 3'd1, 3'd1, 6'b100001), 1'b0, 0);
		add_instr(make_word(lc3b_pkg::op_ldr, 3'd3, 3'd4, 6'd0), 1'b0, 1);
		add_instr(make_word(lc3b_pkg::op_add, 3'd1, 3'd2, 6'b000011), 1'b0, 1);	// add r1,r2,r3
		add_instr(make_word(lc3b_pkg::op_ldr, 3'd3, 3'd4, 6'd0), 1'b0, 1);
		add_instr(make_word(lc3b_pkg::op_add, 3'd1, 3'd2, 6'b100011), 1'b0, 1);	// add r1,r2,#3
		add_instr(make_word(lc3b_pkg::op_ldr, 3'd5, 3'd6, 6'd0), 1'b0, 2);
		add_instr(make_word(lc3b_pkg::op_str, 3'd5, 3'd0, 6'd1), 1'b0, 2);	// data is r5
		add_instr(make_word(lc3b_pkg::op_ldr, 3'd5, 3'd6, 6'd0), 1'b0, 2);
		add_instr(make_word(lc3b_pkg::op_stb, 3'd1, 3'd5, 6'd0), 1'b0, 2);	// base is r5
		add_instr(make_word(lc3b_pkg::op_add, 3'd5, 3'd6, 6'b100010), 1'b0, 2);
		add_instr(make_word(lc3b_pkg::op_str, 3'd5, 3'd0, 6'd1), 1'b0, 2);
		add_instr(make_word(lc3b_pkg::op_br, 3'b111, 3'd0, 6'd4), 1'b0, 3);
		add_instr(make_word(lc3b_pkg::op_add, 3'd2, 3'd2, 6'b100001), 1'b0, 3);
		add_instr(make_word(lc3b_pkg::op_jmp, 3'd0, 3'd2, 6'd0), 1'b0, 3);
		add_instr(make_word(lc3b_pkg::op_add, 3'd2, 3'd2, 6'b100001), 1'b0, 3);
		add_instr(make_word(lc3b_pkg::op_jsr, 3'b100, 3'd0, 6'd8), 1'b0, 3);
		add_instr(make_word(lc3b_pkg::op_add, 3'd2, 3'd2, 6'b100001), 1'b0, 3);
		add_instr(make_word(lc3b_pkg::op_trap, 3'd0, 3'd1, 6'd5), 1'b0, 3);
		add_instr(make_word(lc3b_pkg::op_add, 3'd2, 3'd2, 6'b100001), 1'b0, 3);
		add_instr(16'h0000, 1'b0, 3);
		add_instr(make_word(lc3b_pkg::op_add, 3'd2, 3'd2, 6'b100001), 1'b0, 3);
		add_instr(make_word(lc3b_pkg::op_br, 3'b010, 3'd0, 6'd9), 1'b1, 4);
		add_instr(make_word(lc3b_pkg::op_add, 3'd3, 3'd3, 6'b100001), 1'b0, 4);	// dropped
		add_instr(make_word(lc3b_pkg::op_add, 3'd4, 3'd4, 6'b100001), 1'b0, 4);
		add_instr(make_word(lc3b_pkg::op_jmp, 3'd0, 3'd7, 6'd0), 1'b1, 4);
		add_instr(make_word(lc3b_pkg::op_add, 3'd3, 3'd3, 6'b100001), 1'b0, 4);	// dropped
		add_instr(make_word(lc3b_pkg::op_add, 3'd4, 3'd4, 6'b100001), 1'b0, 4);
		for (i = 0; i < 40; i++)
		begin
			rnd = $random(seed);
			add_instr(rnd[15:0], rnd[16], 5);
		end
		// tail so a late branch still has a shadow slot behind it
		add_instr(make_word(lc3b_pkg::op_add, 3'd0, 3'd0, 6'b100001), 1'b0, 5);
		add_instr(make_word(lc3b_pkg::op_add, 3'd0, 3'd0, 6'b100001), 1'b0, 5);
		ref_issue();

		for (i = 0; i < 10; i++)
		begin
			@(posedge clk);
			#1;
			if (i == 7)
				reset = 1'b0;	// after eight cycles
			assert (!ex_valid && !in_credit)
			else
			begin
				log_failure("ex_valid or in_credit high around reset");
				reset_errs++;
			end
		end
		go = 1'b1;

		n = 0;
		while (!comp_done && n < 50 * MAX_PROG)
		begin
			@(posedge clk);
			n++;
		end
		if (!comp_done)
			$display("ERROR: run did not finish within %0d cycles", n);
		total = reset_errs + credit_errs;
		for (i = 0; i < N_TESTS; i++)
			total += test_errs[i];
		$display("%0d of %0d issues compared, %0d checks failed",
			n_checked, exp_idx.size(), total);
		if (comp_done && !comp_hung && !sender_hung && total == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule : tb_lc3b_issue_pipe

`default_nettype wire

// ==== src.f ====
hw/lc3b_pkg.sv
hw/fetch_credit_if.sv
hw/fetch_buffer.sv
hw/operand_use_decode.sv
hw/hazard_ctrl.sv
hw/decode_stage.sv
hw/lc3b_issue_pipe.sv
test/tb_lc3b_issue_pipe.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_lc3b_issue_pipe
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)
